/* lsu_pkg.sv */
// ========================================
// Shared widths and bus structs of the load-store write-back path
// Tags are allocated outside and must be unique among live entries
// ========================================

package lsu_pkg;

    localparam int TAG_W  = 7;
    localparam int SEQ_W  = 8;   // Program order, compared with wrap-around
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int REG_W  = 5;

    // Request from the issue stage, 86 bits
    typedef struct packed {
        logic              valid;
        logic              is_store;
        logic [TAG_W-1:0]  tag;
        logic [SEQ_W-1:0]  seq;
        logic [REG_W-1:0]  dest;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;      // Store data, ignored for loads
    } mem_req_t;

    typedef struct packed {
        logic [SEQ_W-1:0]  seq;
        logic [REG_W-1:0]  dest;
        logic [ADDR_W-1:0] addr;
    } ld_payload_t;

    typedef struct packed {
        logic [SEQ_W-1:0]  seq;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } st_payload_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } mem_resp_t;

    // Write-back result, dest is zero for stores
    typedef struct packed {
        logic              valid;
        logic              is_store;
        logic [SEQ_W-1:0]  seq;
        logic [REG_W-1:0]  dest;
        logic [DATA_W-1:0] data;
    } wb_t;

endpackage

/* pending_req_queue.sv */
// ========================================
// In-order pending queue, responses matched by tag on live entries
// A write to a truly full queue is dropped; flush overrides all
// ========================================
`timescale 1ns/1ps

module pending_req_queue #(
    parameter int  ENTRIES     = 8,
    parameter int  FULL_MARGIN = 2,
    parameter type payload_t   = lsu_pkg::ld_payload_t
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       write_i,
    input  logic [lsu_pkg::TAG_W-1:0]  tag_i,
    input  payload_t                   payload_i,
    input  lsu_pkg::mem_resp_t         resp_i,
    input  logic                       cancel_i,      // Drop the youngest entry
    input  logic                       flush_i,
    input  logic                       advance_i,     // Pop the head
    output logic                       head_done_o,
    output payload_t                   head_payload_o,
    output logic [lsu_pkg::DATA_W-1:0] head_data_o,
    output logic                       full_o         // Almost full
);
    import lsu_pkg::*;

    localparam int PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
    localparam int CNT_W = PTR_W + 1;
    localparam logic [PTR_W-1:0] LAST_IDX   = PTR_W'(ENTRIES - 1);
    localparam logic [CNT_W-1:0] DEPTH      = CNT_W'(ENTRIES);
    localparam logic [CNT_W-1:0] FULL_LEVEL = CNT_W'(ENTRIES - FULL_MARGIN);

    payload_t          payload_q [ENTRIES];
    logic [TAG_W-1:0]  tag_q     [ENTRIES];
    logic [DATA_W-1:0] data_q    [ENTRIES];
    logic [ENTRIES-1:0] done_q;              // Response seen per entry

    logic [PTR_W-1:0] head_q;   // Oldest entry
    logic [PTR_W-1:0] tail_q;   // Next free slot
    logic [CNT_W-1:0] count_q;

    logic [ENTRIES-1:0] live;
    logic [ENTRIES-1:0] resp_hit;
    logic write_en;
    logic cancel_en;
    logic advance_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_IDX) ? '0 : ptr + 1'b1;
    endfunction

    function automatic logic [PTR_W-1:0] prev_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == '0) ? LAST_IDX : ptr - 1'b1;
    endfunction

    // Distance from head decides whether a slot holds a live entry
    function automatic logic is_live(input int idx, input logic [PTR_W-1:0] hd,
                                     input logic [CNT_W-1:0] cnt);
        int offset;
        offset = (idx >= int'(hd)) ? idx - int'(hd) : idx + ENTRIES - int'(hd);
        return offset < int'(cnt);
    endfunction

    assign advance_en = advance_i & (count_q != '0);
    assign write_en   = write_i & ~cancel_i & (count_q < DEPTH);
    // Never cancel the entry that is being popped in the same cycle
    assign cancel_en  = cancel_i & ~write_i & (count_q > CNT_W'(advance_en));

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            live[i]     = is_live(i, head_q, count_q);
            resp_hit[i] = resp_i.valid & live[i] & (tag_q[i] == resp_i.tag);
        end
    end

    // Entry contents, the write lands after the response so it wins
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < ENTRIES; i++) begin
            if (resp_hit[i]) begin
                data_q[i] <= resp_i.data;
            end
        end
        if (write_en) begin
            payload_q[tail_q] <= payload_i;
            tag_q[tail_q]     <= tag_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_q <= '0;
        end else begin
            for (int i = 0; i < ENTRIES; i++) begin
                if (resp_hit[i]) begin
                    done_q[i] <= 1'b1;
                end
            end
            if (write_en) begin
                done_q[tail_q] <= 1'b0;   // New entry waits for its response
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (advance_en) begin
                head_q <= next_ptr(head_q);
            end
            if (write_en) begin
                tail_q <= next_ptr(tail_q);
            end else if (cancel_en) begin
                tail_q <= prev_ptr(tail_q);
            end
            count_q <= count_q + CNT_W'(write_en) - CNT_W'(advance_en)
                       - CNT_W'(cancel_en);
        end
    end

    assign head_done_o    = (count_q != '0) & done_q[head_q];
    assign head_payload_o = payload_q[head_q];
    assign head_data_o    = data_q[head_q];

    // Held high in reset and flush so the issue stage stalls
    assign full_o = (count_q >= FULL_LEVEL) | flush_i | ~rstn_i;

endmodule

/* wb_select.sv */
// ========================================
// Combinational pick of the older finished queue head
// Sequence numbers compare with wrap, valid within half the range
// ========================================
`timescale 1ns/1ps

module wb_select (
    input  logic                       ld_done_i,
    input  lsu_pkg::ld_payload_t       ld_payload_i,
    input  logic [lsu_pkg::DATA_W-1:0] ld_data_i,
    input  logic                       st_done_i,
    input  lsu_pkg::st_payload_t       st_payload_i,
    input  logic [lsu_pkg::DATA_W-1:0] st_data_i,
    input  logic                       wb_ready_i,
    output lsu_pkg::wb_t               wb_o,
    output logic                       pop_ld_o,
    output logic                       pop_st_o
);
    import lsu_pkg::*;

    logic [SEQ_W-1:0] seq_diff;
    logic ld_older;
    logic pick_ld;
    logic pick_st;

    // Load is older when load seq minus store seq wraps negative
    assign seq_diff = ld_payload_i.seq - st_payload_i.seq;
    assign ld_older = seq_diff[SEQ_W-1];

    assign pick_ld = ld_done_i & (~st_done_i | ld_older);
    assign pick_st = st_done_i & ~pick_ld;

    always_comb begin
        wb_o = '0;
        if (pick_ld) begin
            wb_o.valid    = 1'b1;
            wb_o.is_store = 1'b0;
            wb_o.seq      = ld_payload_i.seq;
            wb_o.dest     = ld_payload_i.dest;
            wb_o.data     = ld_data_i;
        end else if (pick_st) begin
            wb_o.valid    = 1'b1;
            wb_o.is_store = 1'b1;
            wb_o.seq      = st_payload_i.seq;
            wb_o.dest     = '0;           // Stores have no destination
            wb_o.data     = st_data_i;
        end
    end

    // Head advances only when the consumer takes the result
    assign pop_ld_o = pick_ld & wb_ready_i;
    assign pop_st_o = pick_st & wb_ready_i;

endmodule

/* lsu_wb_top.sv */
// ========================================
// Write-back side of the LSU, separate load and store queues
// Tag allocation and the memory itself live outside
// ========================================
`timescale 1ns/1ps

module lsu_wb_top #(
    parameter int LQ_ENTRIES  = 8,
    parameter int SQ_ENTRIES  = 4,
    parameter int FULL_MARGIN = 2
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  lsu_pkg::mem_req_t  req_i,
    input  logic               cancel_i,
    input  logic               cancel_store_i,  // Cancel targets the store queue
    input  lsu_pkg::mem_resp_t resp_i,
    input  logic               flush_i,
    input  logic               wb_ready_i,
    output lsu_pkg::wb_t       wb_o,
    output logic               ld_full_o,
    output logic               st_full_o
);
    import lsu_pkg::*;

    ld_payload_t ld_payload;
    st_payload_t st_payload;
    ld_payload_t ld_head_payload;
    st_payload_t st_head_payload;
    logic [DATA_W-1:0] ld_head_data;
    logic [DATA_W-1:0] st_head_data;
    logic ld_write, st_write;
    logic ld_cancel, st_cancel;
    logic ld_done, st_done;
    logic pop_ld, pop_st;

    // Split by kind
    assign ld_write  = req_i.valid & ~req_i.is_store;
    assign st_write  = req_i.valid & req_i.is_store;
    assign ld_cancel = cancel_i & ~cancel_store_i;
    assign st_cancel = cancel_i & cancel_store_i;

    assign ld_payload.seq  = req_i.seq;
    assign ld_payload.dest = req_i.dest;
    assign ld_payload.addr = req_i.addr;

    assign st_payload.seq  = req_i.seq;
    assign st_payload.addr = req_i.addr;
    assign st_payload.data = req_i.data;

    pending_req_queue #(
        .ENTRIES     (LQ_ENTRIES),
        .FULL_MARGIN (FULL_MARGIN),
        .payload_t   (ld_payload_t)
    ) i_load_queue (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .write_i        (ld_write),
        .tag_i          (req_i.tag),
        .payload_i      (ld_payload),
        .resp_i         (resp_i),
        .cancel_i       (ld_cancel),
        .flush_i        (flush_i),
        .advance_i      (pop_ld),
        .head_done_o    (ld_done),
        .head_payload_o (ld_head_payload),
        .head_data_o    (ld_head_data),
        .full_o         (ld_full_o)
    );

    pending_req_queue #(
        .ENTRIES     (SQ_ENTRIES),
        .FULL_MARGIN (FULL_MARGIN),
        .payload_t   (st_payload_t)
    ) i_store_queue (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .write_i        (st_write),
        .tag_i          (req_i.tag),
        .payload_i      (st_payload),
        .resp_i         (resp_i),         // Broadcast, tags are unique
        .cancel_i       (st_cancel),
        .flush_i        (flush_i),
        .advance_i      (pop_st),
        .head_done_o    (st_done),
        .head_payload_o (st_head_payload),
        .head_data_o    (st_head_data),
        .full_o         (st_full_o)
    );

    wb_select i_wb_select (
        .ld_done_i    (ld_done),
        .ld_payload_i (ld_head_payload),
        .ld_data_i    (ld_head_data),
        .st_done_i    (st_done),
        .st_payload_i (st_head_payload),
        .st_data_i    (st_head_data),
        .wb_ready_i   (wb_ready_i),
        .wb_o         (wb_o),
        .pop_ld_o     (pop_ld),
        .pop_st_o     (pop_st)
    );

endmodule

/* tb_lsu_wb.sv */
// ========================================
// Random traffic from seed 29 checked against a queue model
// Tags are allocated here and reused only once fully retired
// ========================================
`timescale 1ns/1ps

module tb_lsu_wb;
    import lsu_pkg::*;

    localparam int LQ_ENTRIES   = 8;
    localparam int SQ_ENTRIES   = 4;
    localparam int FULL_MARGIN  = 2;
    localparam int RESET_CYCLES = 16;
    localparam int TEST_CYCLES  = 350;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 6 * TEST_CYCLES;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 200) * 10;

    // Model entry
    // mq[0] holds the load queue and mq[1] the store queue
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [SEQ_W-1:0]  seq;
        logic [REG_W-1:0]  dest;
        logic              done;
        logic [DATA_W-1:0] rdata;
    } ent_t;

    logic clk_i, rstn_i, cancel_i, cancel_store_i, flush_i, wb_ready_i;
    logic ld_full_o, st_full_o;
    mem_req_t  req_i;
    mem_resp_t resp_i;
    wb_t       wb_o;

    ent_t mq [2][$];
    logic [TAG_W-1:0] pend_tag [$];   // Responses still owed by memory
    int pend_dly [$];
    logic [SEQ_W-1:0] seq_cnt;
    int seed;
    int load_pct, store_pct, ready_pct, cancel_pct, flush_pct, dly_max;
    int n_checks, n_err, n_wb, n_tests;

    lsu_wb_top #(
        .LQ_ENTRIES  (LQ_ENTRIES),
        .SQ_ENTRIES  (SQ_ENTRIES),
        .FULL_MARGIN (FULL_MARGIN)
    ) i_lsu_wb_top (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_i          (req_i),
        .cancel_i       (cancel_i),
        .cancel_store_i (cancel_store_i),
        .resp_i         (resp_i),
        .flush_i        (flush_i),
        .wb_ready_i     (wb_ready_i),
        .wb_o           (wb_o),
        .ld_full_o      (ld_full_o),
        .st_full_o      (st_full_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int depth_of(input int s);
        return (s == 0) ? LQ_ENTRIES : SQ_ENTRIES;
    endfunction

    // The older finished head wins by wrapped sequence order
    function automatic wb_t expected_wb();
        wb_t w;
        logic ld_ok, st_ok, pick_ld;
        logic [SEQ_W-1:0] diff;
        w = '0;
        ld_ok = (mq[0].size() > 0) && mq[0][0].done;
        st_ok = (mq[1].size() > 0) && mq[1][0].done;
        pick_ld = ld_ok;
        if (ld_ok && st_ok) begin
            diff = mq[0][0].seq - mq[1][0].seq;
            pick_ld = diff[SEQ_W-1];
        end
        if (pick_ld) begin
            w.valid = 1'b1;
            w.seq   = mq[0][0].seq;
            w.dest  = mq[0][0].dest;
            w.data  = mq[0][0].rdata;
        end else if (st_ok) begin
            w.valid    = 1'b1;
            w.is_store = 1'b1;
            w.seq      = mq[1][0].seq;
            w.data     = mq[1][0].rdata;
        end
        return w;
    endfunction

    function automatic logic expected_full(input int s);
        return !rstn_i || flush_i || (mq[s].size() >= depth_of(s) - FULL_MARGIN);
    endfunction

    function automatic logic tag_is_free(input int t);
        foreach (pend_tag[k]) begin
            if (int'(pend_tag[k]) == t) return 1'b0;
        end
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < mq[s].size(); k++) begin
                if (int'(mq[s][k].tag) == t) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic int pick_free_tag();
        int start;
        int cand;
        start = rnd(1 << TAG_W);
        for (int i = 0; i < (1 << TAG_W); i++) begin
            cand = (start + i) % (1 << TAG_W);
            if (tag_is_free(cand)) return cand;
        end
        return -1;
    endfunction

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        n_checks++;
        if (act !== exp) begin
            n_err++;
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_err++;
            $display("MISMATCH t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_outputs();
        check_wb("wb_o", expected_wb(), wb_o);
        check_flag("ld_full_o", expected_full(0), ld_full_o);
        check_flag("st_full_o", expected_full(1), st_full_o);
    endtask

    // Apply the inputs of the cycle that just ended as the DUT does at this edge
    task automatic model_step();
        wb_t w;
        ent_t e;
        logic [1:0] pop, wr, cn;
        logic truly_full;
        w = expected_wb();
        pop[0] = w.valid & ~w.is_store & wb_ready_i;
        pop[1] = w.valid & w.is_store & wb_ready_i;
        wr[0]  = req_i.valid & ~req_i.is_store;
        wr[1]  = req_i.valid & req_i.is_store;
        cn[0]  = cancel_i & ~cancel_store_i;
        cn[1]  = cancel_i & cancel_store_i;
        if (|pop && !flush_i) n_wb++;
        for (int s = 0; s < 2; s++) begin
            if (flush_i) begin
                mq[s].delete();
            end else begin
                for (int j = 0; j < mq[s].size(); j++) begin
                    if (resp_i.valid && mq[s][j].tag == resp_i.tag) begin
                        e = mq[s][j];
                        e.done  = 1'b1;
                        e.rdata = resp_i.data;
                        mq[s][j] = e;
                    end
                end
                truly_full = mq[s].size() >= depth_of(s);   // Before this edge's pop
                if (pop[s]) void'(mq[s].pop_front());
                if (wr[s] && !cn[s] && !truly_full) begin
                    e = '0;
                    e.tag  = req_i.tag;
                    e.seq  = req_i.seq;
                    e.dest = wr[1] ? '0 : req_i.dest;
                    mq[s].push_back(e);
                end else if (cn[s] && !wr[s] && mq[s].size() > 0) begin
                    void'(mq[s].pop_back());
                end
            end
        end
    endtask

    task automatic drive_inputs();
        mem_req_t  r;
        mem_resp_t p;
        int roll, t;
        r = '0;
        p = '0;
        foreach (pend_dly[k]) begin
            pend_dly[k]--;   // Age owed responses before adding new ones
        end
        for (int k = 0; k < pend_dly.size(); k++) begin
            if (pend_dly[k] <= 0) begin
                p.valid = 1'b1;
                p.tag   = pend_tag[k];
                p.data  = $random(seed);
                pend_tag.delete(k);
                pend_dly.delete(k);
                break;
            end
        end
        roll = rnd(100);
        t = (roll < load_pct + store_pct) ? pick_free_tag() : -1;
        if (t >= 0) begin
            r.valid    = 1'b1;
            r.is_store = (roll >= load_pct);
            r.tag      = TAG_W'(t);
            r.seq      = seq_cnt;
            r.dest     = REG_W'(rnd(32));
            r.addr     = $random(seed);
            r.data     = $random(seed);
            seq_cnt    = seq_cnt + SEQ_W'(1);
            pend_tag.push_back(r.tag);
            pend_dly.push_back(1 + rnd(dly_max));
        end
        req_i          <= r;
        resp_i         <= p;
        cancel_i       <= (rnd(100) < cancel_pct);
        cancel_store_i <= rnd(2) == 1;
        flush_i        <= (rnd(100) < flush_pct);
        wb_ready_i     <= (rnd(100) < ready_pct);
    endtask

    task automatic run_test(input string name, input int l, input int s, input int r,
                            input int c, input int f, input int d);
        int err0, chk0, wb0;
        err0 = n_err;
        chk0 = n_checks;
        wb0  = n_wb;
        load_pct   = l;
        store_pct  = s;
        ready_pct  = r;
        cancel_pct = c;
        flush_pct  = f;
        dly_max    = d;
        repeat (TEST_CYCLES) begin
            @(negedge clk_i);
            check_outputs();
            @(posedge clk_i);
            model_step();
            drive_inputs();
        end
        if (n_wb == wb0) begin
            n_err++;
            $display("Test %s produced no write-back at all", name);
        end
        n_tests++;
        $display("Test %0d %s done: %0d checks, %0d errors, %0d write-backs", n_tests, name,
                 n_checks - chk0, n_err - err0, n_wb - wb0);
    endtask

    initial begin
        clk_i = 1'b0;
        rstn_i = 1'b0;
        req_i = '0;
        resp_i = '0;
        cancel_i = 1'b0;
        cancel_store_i = 1'b0;
        flush_i = 1'b0;
        wb_ready_i = 1'b0;
        seed = 29;
        seq_cnt = '0;
        n_checks = 0;
        n_err = 0;
        n_wb = 0;
        n_tests = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk_i);
            check_outputs();   // Flags stay high with no write-back
        end
        @(posedge clk_i);
        rstn_i <= 1'b1;
        $display("Reset done: %0d checks, %0d errors", n_checks, n_err);
        //       name               load store ready cancel flush delay
        run_test("loads_in_order",    45,   0,  100,    0,    0,  12);
        run_test("mixed_seq_wrap",    35,  35,  100,    0,    0,  10);
        run_test("backpressure",      30,  30,   40,    0,    0,   8);
        run_test("almost_full",       45,  45,   50,    0,    0,  24);
        run_test("cancel_youngest",   30,  30,   80,   25,    0,   8);
        run_test("flush",             30,  30,   80,    5,    4,   8);
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d write-backs",
                 n_tests, n_checks, n_err, n_wb);
        if (n_err == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

/* src.f */
lsu_pkg.sv
pending_req_queue.sv
wb_select.sv
lsu_wb_top.sv
tb_lsu_wb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and decide on the pass message
set -u
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_lsu_wb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_lsu_wb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
